// ==== test/raster_input.txt ====
# name x0 y0 x1 y1 x2 y2 | box min_x max_x min_y max_y | count sum_x sum_y
# box is the clamped one, min above max marks an empty box
ccw_unit         0    0    4    0    0    4     0   4   0   4      15     20     20
cw_unit          0    0    0    4    4    0     0   4   0   4       0      0      0
ccw_small       30   20   31   20   30   21    30  31  20  21       3     91     61
ccw_large       20   15   30   15   20   25    20  30  15  25      66   1540   1210
ccw_mirror      44   30   44   34   40   30    40  44  30  34      15    640    470
ccw_rotated      5   40    1   44    1   40     1   5  40  44      15     35    620
ccw_kite        10   10   16   13   10   16    10  16  10  16      25    297    325
cw_kite         10   10   10   16   16   13    10  16  10  16       0      0      0
clamp_top_left  -3   -3    5   -3   -3    5     0   5   0   5       6      4      4
clamp_bot_right 60   44   70   44   60   54    60  63  44  47      16    984    728
clamp_top       30   -2   34   -2   30    2    30  34   0   2       6    184      4
clamp_full    -100 -100  300 -100 -100  300     0  63   0  47    3072  96768  72192
off_left       -20  -20  -10  -20  -20  -10     0 -10   0 -10       0      0      0
off_right       70   10   80   10   70   20    70  63  10  20       0      0      0
line_horiz       2    2    6    2    4    2     2   6   2   2       5     20     10
line_diag        1    1    5    5    3    3     1   5   1   5       5     15     15
point            7    7    7    7    7    7     7   7   7   7       1      7      7

// ==== tb.f ====
hdl/geom_pkg.sv
hdl/raster_pkg.sv
hdl/tri_bbox.sv
hdl/edge_setup.sv
hdl/scan_walker.sv
hdl/triangle_raster.sv
test/raster_checker.sv
test/raster_tb.sv

// ==== Bender.yml ====
package:
  name: triangle_raster

sources:
  - hdl/geom_pkg.sv
  - hdl/raster_pkg.sv
  - hdl/tri_bbox.sv
  - hdl/edge_setup.sv
  - hdl/scan_walker.sv
  - hdl/triangle_raster.sv
  - target: test
    files:
      - test/raster_checker.sv
      - test/raster_tb.sv

// ==== test/raster_tb.sv ====
`timescale 1ns/1ps

module raster_tb;
    import geom_pkg::*;
    import raster_pkg::*;

    localparam int SCREEN_W     = 64;
    localparam int SCREEN_H     = 48;
    localparam int RESET_CYCLES = 5;

    typedef struct packed {
        logic [127:0] name;
        triangle_t    shape;
        bbox_t        box;
        int           count;
        int           sum_x;
        int           sum_y;
    } test_rec_t;

    logic        clk;
    logic        rst;
    triangle_t   triangle;
    logic        tri_valid;
    logic        busy;
    fragment_t   frag;
    logic        frag_valid;
    logic        done;
    test_rec_t   tests[$];
    test_rec_t   cur;
    logic [15:0] lfsr;
    int          limit;
    logic        limit_ready;
    int          cycles;
    int          gap;
    int          load_errors;
    int          tests_done;
    int          tests_failed;
    int          other_errors;

    triangle_raster #(
        .SCREEN_W (SCREEN_W),
        .SCREEN_H (SCREEN_H)
    ) dut0 (
        .clk        (clk),
        .rst        (rst),
        .triangle   (triangle),
        .tri_valid  (tri_valid),
        .busy       (busy),
        .frag       (frag),
        .frag_valid (frag_valid),
        .done       (done)
    );

    raster_checker chk0 (
        .clk          (clk),
        .rst          (rst),
        .tri_valid    (tri_valid),
        .busy         (busy),
        .frag         (frag),
        .frag_valid   (frag_valid),
        .done         (done),
        .exp_name     (cur.name),
        .exp_box      (cur.box),
        .exp_count    (cur.count),
        .exp_sum_x    (cur.sum_x),
        .exp_sum_y    (cur.sum_y),
        .tests_done   (tests_done),
        .tests_failed (tests_failed),
        .other_errors (other_errors)
    );

    initial
    begin
        clk = 1'b0;
        forever
            #20 clk = ~clk;
    end

    // Galois form, taps 16, 14, 13, 11
    function automatic logic next_random_bit();
        logic b;
        b    = lfsr[0];
        lfsr = lfsr >> 1;
        if (b)
            lfsr = lfsr ^ 16'hB400;
        return b;
    endfunction

    function automatic int box_area(input bbox_t b);
        if (b.empty)
            return 0;
        return (b.max_x - b.min_x + 1) * (b.max_y - b.min_y + 1);
    endfunction

    ///////////////////////////////
    // Stimulus file
    ///////////////////////////////

    task automatic read_tests();
        int           fd;
        int           n;
        string        line;
        logic [127:0] tname;
        int           f [0:12];
        test_rec_t    rec;
        fd = $fopen("test/raster_input.txt", "r");
        if (fd == 0)
        begin
            $display("Cannot open test/raster_input.txt");
            load_errors++;
        end
        else
        begin
            while ($fgets(line, fd) > 0)
            begin
                if (line.len() > 1 && line[0] != "#")
                begin
                    n = $sscanf(line, "%s %d %d %d %d %d %d %d %d %d %d %d %d %d", tname,
                                f[0], f[1], f[2], f[3], f[4], f[5], f[6], f[7], f[8],
                                f[9], f[10], f[11], f[12]);
                    if (n != 14)
                    begin
                        $display("Unreadable line in test/raster_input.txt: %0s", line);
                        load_errors++;
                    end
                    else
                    begin
                        rec.name       = tname;
                        rec.shape.v0.x = coord_t'(f[0]);
                        rec.shape.v0.y = coord_t'(f[1]);
                        rec.shape.v1.x = coord_t'(f[2]);
                        rec.shape.v1.y = coord_t'(f[3]);
                        rec.shape.v2.x = coord_t'(f[4]);
                        rec.shape.v2.y = coord_t'(f[5]);
                        rec.box.min_x  = coord_t'(f[6]);
                        rec.box.max_x  = coord_t'(f[7]);
                        rec.box.min_y  = coord_t'(f[8]);
                        rec.box.max_y  = coord_t'(f[9]);
                        rec.box.empty  = (f[6] > f[7]) || (f[8] > f[9]);
                        rec.count      = f[10];
                        rec.sum_x      = f[11];
                        rec.sum_y      = f[12];
                        tests.push_back(rec);
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic wait_idle();
        do
        begin
            @(posedge clk);
            #2;
        end
        while (busy);
    endtask

    task automatic send_triangle(input test_rec_t t);
        cur       = t;
        triangle  = t.shape;
        tri_valid = 1'b1;
        @(posedge clk);
        #2;
        tri_valid = 1'b0;
    endtask

    ///////////////////////////////
    // Main sequence
    ///////////////////////////////

    initial
    begin
        rst         = 1'b1;
        tri_valid   = 1'b0;
        triangle    = '0;
        cur         = '0;
        lfsr        = 16'd97;
        load_errors = 0;
        limit_ready = 1'b0;
        read_tests();
        limit = RESET_CYCLES;
        foreach (tests[i])
            limit += box_area(tests[i].box) + 8;
        limit_ready = 1'b1;
        repeat (RESET_CYCLES) @(posedge clk);
        #2;
        rst = 1'b0;
        foreach (tests[i])
        begin
            wait_idle();
            gap = int'(next_random_bit());
            gap = gap | (int'(next_random_bit()) << 1);
            repeat (gap)
            begin
                @(posedge clk);
                #2;
            end
            send_triangle(tests[i]);
        end
        while (tests_done < tests.size())
            @(posedge clk);
        $display("Tests run %0d, passed %0d, failed %0d, other errors %0d",
                 tests_done, tests_done - tests_failed, tests_failed,
                 other_errors + load_errors);
        if (tests.size() > 0 && tests_failed == 0 && other_errors == 0 && load_errors == 0)
            $display("TEST PASSED");
        else
            $display("TEST FAILED");
        $finish;
    end

    initial
    begin
        cycles = 0;
        wait (limit_ready);
        while (cycles < limit)
        begin
            @(posedge clk);
            cycles++;
        end
        $display("Timeout after %0d cycles, done never arrived for every triangle", limit);
        $display("TEST FAILED");
        $finish;
    end

endmodule

// ==== test/raster_checker.sv ====
`timescale 1ns/1ps

module raster_checker (
    input  logic                  clk,
    input  logic                  rst,
    input  logic                  tri_valid,
    input  logic                  busy,
    input  raster_pkg::fragment_t frag,
    input  logic                  frag_valid,
    input  logic                  done,
    input  logic [127:0]          exp_name,
    input  geom_pkg::bbox_t       exp_box,
    input  int                    exp_count,
    input  int                    exp_sum_x,
    input  int                    exp_sum_y,
    output int                    tests_done,
    output int                    tests_failed,
    output int                    other_errors
);
    import geom_pkg::*;

    int           done_cnt = 0;
    int           fail_cnt = 0;
    int           err_cnt = 0;
    logic         in_test;
    logic         failed;
    logic         busy_err;
    logic         have_prev;
    logic [127:0] name;
    bbox_t        box;
    int           want_count;
    int           want_sx;
    int           want_sy;
    int           n_frag;
    int           sum_x;
    int           sum_y;
    int           prev_x;
    int           prev_y;
    int           cycle;

    assign tests_done   = done_cnt;
    assign tests_failed = fail_cnt;
    assign other_errors = err_cnt;

    task automatic check_value(input string what, input int expected, input int actual);
        if (expected != actual)
        begin
            $display("Mismatch %0s %0s: expected %0d, actual %0d",
                     name, what, expected, actual);
            failed = 1'b1;
        end
    endtask

    ///////////////////////////////
    // Per-triangle bookkeeping
    ///////////////////////////////

    // Expectations are latched on the accepted strobe, since the next
    // triangle may already be loaded while done is high
    task automatic start_test();
        name       = exp_name;
        box        = exp_box;
        want_count = exp_count;
        want_sx    = exp_sum_x;
        want_sy    = exp_sum_y;
        n_frag     = 0;
        sum_x      = 0;
        sum_y      = 0;
        cycle      = 0;
        failed     = 1'b0;
        busy_err   = 1'b0;
        have_prev  = 1'b0;
        in_test    = 1'b1;
    endtask

    task automatic take_fragment();
        int fx;
        int fy;
        fx = int'(frag.x);
        fy = int'(frag.y);
        // An empty box has min above max, so nothing passes
        if (fx < box.min_x || fx > box.max_x || fy < box.min_y || fy > box.max_y)
        begin
            $display("Fragment (%0d, %0d) of %0s lies outside its box", fx, fy, name);
            failed = 1'b1;
        end
        if (have_prev && !(fy > prev_y || (fy == prev_y && fx > prev_x)))
        begin
            $display("Fragment (%0d, %0d) of %0s is out of row-major order", fx, fy, name);
            failed = 1'b1;
        end
        have_prev = 1'b1;
        prev_x    = fx;
        prev_y    = fy;
        n_frag++;
        sum_x += fx;
        sum_y += fy;
    endtask

    task automatic finish_test();
        int area;
        if (box.empty)
            area = 0;
        else
            area = (box.max_x - box.min_x + 1) * (box.max_y - box.min_y + 1);
        check_value("fragment count", want_count, n_frag);
        check_value("sum of x", want_sx, sum_x);
        check_value("sum of y", want_sy, sum_y);
        // Cycle 0 carries the accepted strobe
        check_value("cycles to done", 3 + area, cycle);
        if (busy)
        begin
            $display("busy still high while done pulses for %0s", name);
            failed = 1'b1;
        end
        done_cnt++;
        if (failed)
        begin
            fail_cnt++;
            $display("Test %0s failed", name);
        end
        else
        begin
            $display("Test %0s ok, %0d fragments in %0d cycles", name, n_frag, cycle);
        end
        in_test = 1'b0;
    endtask

    ///////////////////////////////
    // Port watcher
    ///////////////////////////////

    // Sampled mid-cycle where every DUT output is settled
    always @(negedge clk)
    begin
        if (rst)
        begin
            in_test = 1'b0;
            if (frag_valid !== 1'b0 || done !== 1'b0 || busy !== 1'b0)
            begin
                $display("DUT outputs are not idle during reset");
                err_cnt++;
            end
        end
        else
        begin
            if (in_test)
                cycle++;
            if (frag_valid)
            begin
                if (in_test)
                    take_fragment();
                else
                begin
                    $display("Fragment (%0d, %0d) arrived with no triangle in flight",
                             int'(frag.x), int'(frag.y));
                    err_cnt++;
                end
            end
            if (done)
            begin
                if (in_test)
                    finish_test();
                else
                begin
                    $display("done pulsed with no triangle in flight");
                    err_cnt++;
                end
            end
            else if (in_test && cycle > 0 && !busy && !busy_err)
            begin
                $display("busy was low before done for %0s", name);
                busy_err = 1'b1;
                failed   = 1'b1;
            end
            // A strobe in the cycle done is high opens the next test
            if (tri_valid)
            begin
                if (busy)
                begin
                    $display("tri_valid was sent while busy was high");
                    err_cnt++;
                end
                else
                begin
                    if (in_test)
                    begin
                        $display("A new triangle was accepted before %0s reached done",
                                 name);
                        err_cnt++;
                    end
                    start_test();
                end
            end
        end
    end

endmodule

// ==== hdl/triangle_raster.sv ====
`timescale 1ns/1ps

module triangle_raster #(
    parameter int SCREEN_W = 64,
    parameter int SCREEN_H = 48
) (
    input  logic                  clk,
    input  logic                  rst,
    input  geom_pkg::triangle_t   triangle,
    input  logic                  tri_valid,
    output logic                  busy,
    output raster_pkg::fragment_t frag,
    output logic                  frag_valid,
    output logic                  done
);
    import geom_pkg::*;
    import raster_pkg::*;

    bbox_t      box;
    tri_edges_t edges;
    logic       box_valid;
    logic       accept;
    logic       pending;
    logic       active;

    // Strobes during a walk are dropped
    assign accept = tri_valid && !busy;

    // Covers the setup cycles until the walker takes over
    always_ff @(posedge clk)
    begin
        if (rst)
            pending <= 1'b0;
        else if (accept)
            pending <= 1'b1;
        else if (box_valid)
            pending <= 1'b0;
    end

    assign busy = pending || active;

    tri_bbox #(
        .SCREEN_W (SCREEN_W),
        .SCREEN_H (SCREEN_H)
    ) u_bbox (
        .clk       (clk),
        .rst       (rst),
        .triangle  (triangle),
        .tri_valid (accept),
        .box       (box),
        .box_valid (box_valid)
    );

    edge_setup u_edges (
        .clk       (clk),
        .rst       (rst),
        .triangle  (triangle),
        .tri_valid (accept),
        .edges     (edges)
    );

    scan_walker u_walker (
        .clk         (clk),
        .rst         (rst),
        .box         (box),
        .edges       (edges),
        .setup_valid (box_valid),
        .active      (active),
        .frag        (frag),
        .frag_valid  (frag_valid),
        .done        (done)
    );

endmodule

// ==== hdl/scan_walker.sv ====
`timescale 1ns/1ps

module scan_walker (
    input  logic                   clk,
    input  logic                   rst,
    input  geom_pkg::bbox_t        box,
    input  raster_pkg::tri_edges_t edges,
    input  logic                   setup_valid,
    output logic                   active,
    output raster_pkg::fragment_t  frag,
    output logic                   frag_valid,
    output logic                   done
);
    import geom_pkg::*;
    import raster_pkg::*;

    typedef enum logic [1:0] {
        S_IDLE,
        S_START,
        S_WALK
    } state_t;

    state_t     state;
    coord_t     x_cnt;
    coord_t     y_cnt;
    edge_coef_t coef   [0:2];
    edge_val_t  corner [0:2];
    edge_val_t  ev     [0:2];
    edge_val_t  row    [0:2];
    logic       last_col;
    logic       last_row;
    logic       covered;

    function automatic edge_val_t eval_at(input edge_coef_t e, input coord_t x, input coord_t y);
        edge_val_t xe;
        edge_val_t ye;
        xe = edge_val_t'(x);
        ye = edge_val_t'(y);
        return (e.a * xe) + (e.b * ye) + e.c;
    endfunction

    assign coef[0] = edges.e0;
    assign coef[1] = edges.e1;
    assign coef[2] = edges.e2;

    // Edge values at the top-left corner of the box
    always_comb
    begin
        for (int i = 0; i < 3; i++)
            corner[i] = eval_at(coef[i], box.min_x, box.min_y);
    end

    assign last_col = (x_cnt == box.max_x);
    assign last_row = (y_cnt == box.max_y);
    // Sign bits only, zero counts as inside
    assign covered  = !ev[0][EDGE_W-1] && !ev[1][EDGE_W-1] && !ev[2][EDGE_W-1];

    assign active     = (state != S_IDLE);
    assign frag_valid = (state == S_WALK) && covered;
    assign frag.x     = x_cnt;
    assign frag.y     = y_cnt;

    ///////////////////////////////
    // Control
    ///////////////////////////////

    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            state <= S_IDLE;
            done  <= 1'b0;
        end
        else
        begin
            done <= 1'b0;
            case (state)
                S_IDLE:
                begin
                    if (setup_valid)
                        state <= S_START;
                end
                S_START:
                begin
                    if (box.empty)
                    begin
                        state <= S_IDLE;
                        done  <= 1'b1;
                    end
                    else
                    begin
                        state <= S_WALK;
                    end
                end
                S_WALK:
                begin
                    if (last_col && last_row)
                    begin
                        state <= S_IDLE;
                        done  <= 1'b1;
                    end
                end
                default:
                begin
                    state <= S_IDLE;
                end
            endcase
        end
    end

    ///////////////////////////////
    // Counters and edge values
    ///////////////////////////////

    always_ff @(posedge clk)
    begin
        if (state == S_START)
        begin
            x_cnt <= box.min_x;
            y_cnt <= box.min_y;
            for (int i = 0; i < 3; i++)
            begin
                ev[i]  <= corner[i];
                row[i] <= corner[i];
            end
        end
        else if (state == S_WALK)
        begin
            if (last_col)
            begin
                // Next row starts from the row copy plus b
                x_cnt <= box.min_x;
                y_cnt <= y_cnt + coord_t'(1);
                for (int i = 0; i < 3; i++)
                begin
                    ev[i]  <= row[i] + coef[i].b;
                    row[i] <= row[i] + coef[i].b;
                end
            end
            else
            begin
                x_cnt <= x_cnt + coord_t'(1);
                for (int i = 0; i < 3; i++)
                    ev[i] <= ev[i] + coef[i].a;
            end
        end
    end

endmodule

// ==== hdl/edge_setup.sv ====
`timescale 1ns/1ps

module edge_setup (
    input  logic                   clk,
    input  logic                   rst,
    input  geom_pkg::triangle_t    triangle,
    input  logic                   tri_valid,
    output raster_pkg::tri_edges_t edges
);
    import geom_pkg::*;
    import raster_pkg::*;

    edge_coef_t coef0, coef1, coef2;

    ///////////////////////////////
    // Coefficients of one edge
    ///////////////////////////////

    // Inside of the edge is where E >= 0
    function automatic edge_coef_t make_coef(input vertex_t s, input vertex_t e);
        edge_val_t  xs;
        edge_val_t  ys;
        edge_val_t  xe;
        edge_val_t  ye;
        edge_coef_t r;
        xs = edge_val_t'(s.x);
        ys = edge_val_t'(s.y);
        xe = edge_val_t'(e.x);
        ye = edge_val_t'(e.y);
        r.a = ys - ye;
        r.b = xe - xs;
        r.c = (xs * ye) - (xe * ys);
        return r;
    endfunction

    assign coef0 = make_coef(triangle.v0, triangle.v1);
    assign coef1 = make_coef(triangle.v1, triangle.v2);
    assign coef2 = make_coef(triangle.v2, triangle.v0);

    ///////////////////////////////
    // Registered result
    ///////////////////////////////

    // Loads in step with tri_bbox, so the box valid pulse covers both
    always_ff @(posedge clk)
    begin
        if (rst)
        begin
            edges <= '0;
        end
        else if (tri_valid)
        begin
            edges.e0 <= coef0;
            edges.e1 <= coef1;
            edges.e2 <= coef2;
        end
    end

endmodule

// ==== hdl/tri_bbox.sv ====
`timescale 1ns/1ps

module tri_bbox #(
    parameter int SCREEN_W = 64,
    parameter int SCREEN_H = 48
) (
    input  logic                clk,
    input  logic                rst,
    input  geom_pkg::triangle_t triangle,
    input  logic                tri_valid,
    output geom_pkg::bbox_t     box,
    output logic                box_valid
);
    import geom_pkg::*;

    localparam coord_t X_MAX = coord_t'(SCREEN_W - 1);
    localparam coord_t Y_MAX = coord_t'(SCREEN_H - 1);

    coord_t mn_x, mx_x, mn_y, mx_y;
    coord_t lo_x, hi_x, lo_y, hi_y;

    function automatic coord_t min3(input coord_t a, input coord_t b, input coord_t c);
        coord_t m;
        m = (a < b) ? a : b;
        return (c < m) ? c : m;
    endfunction

    function automatic coord_t max3(input coord_t a, input coord_t b, input coord_t c);
        coord_t m;
        m = (a > b) ? a : b;
        return (c > m) ? c : m;
    endfunction

    assign mn_x = min3(triangle.v0.x, triangle.v1.x, triangle.v2.x);
    assign mx_x = max3(triangle.v0.x, triangle.v1.x, triangle.v2.x);
    assign mn_y = min3(triangle.v0.y, triangle.v1.y, triangle.v2.y);
    assign mx_y = max3(triangle.v0.y, triangle.v1.y, triangle.v2.y);

    // Only the inner side of each bound is clamped, so an off-screen
    // triangle ends up with min above max
    assign lo_x = (mn_x < 0) ? '0 : mn_x;
    assign hi_x = (mx_x > X_MAX) ? X_MAX : mx_x;
    assign lo_y = (mn_y < 0) ? '0 : mn_y;
    assign hi_y = (mx_y > Y_MAX) ? Y_MAX : mx_y;

    always_ff @(posedge clk)
    begin
        if (tri_valid)
        begin
            box.min_x <= lo_x;
            box.max_x <= hi_x;
            box.min_y <= lo_y;
            box.max_y <= hi_y;
            box.empty <= (lo_x > hi_x) || (lo_y > hi_y);
        end
    end

    always_ff @(posedge clk)
    begin
        if (rst)
            box_valid <= 1'b0;
        else
            box_valid <= tri_valid;
    end

endmodule

// ==== hdl/raster_pkg.sv ====
package raster_pkg;

    ///////////////////////////////
    // Edge functions and output
    ///////////////////////////////

    // Wide enough for any product or running sum
    localparam int EDGE_W = 2 * geom_pkg::COORD_W + 2;

    typedef logic signed [EDGE_W-1:0] edge_val_t;

    // E(x, y) = a*x + b*y + c
    typedef struct packed {
        edge_val_t a;
        edge_val_t b;
        edge_val_t c;
    } edge_coef_t;

    // e0 is v0 to v1, e1 is v1 to v2, e2 is v2 to v0
    typedef struct packed {
        edge_coef_t e0;
        edge_coef_t e1;
        edge_coef_t e2;
    } tri_edges_t;

    typedef struct packed {
        geom_pkg::coord_t x;
        geom_pkg::coord_t y;
    } fragment_t;

endpackage

// ==== hdl/geom_pkg.sv ====
package geom_pkg;

    ///////////////////////////////
    // Screen-space geometry
    ///////////////////////////////

    localparam int COORD_W = 12;

    typedef logic signed [COORD_W-1:0] coord_t;

    typedef struct packed {
        coord_t x;
        coord_t y;
    } vertex_t;

    // Counter-clockwise order (y down) gives a visible triangle
    typedef struct packed {
        vertex_t v0;
        vertex_t v1;
        vertex_t v2;
    } triangle_t;

    // Box bounds are inclusive pixel coordinates
    typedef struct packed {
        coord_t min_x;
        coord_t max_x;
        coord_t min_y;
        coord_t max_y;
        logic   empty;
    } bbox_t;

endpackage
